//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the result
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f sim.f --top-module tb_peri_top \
    -Mdir obj_dir -o tb_peri_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# the error limit is raised so that assertion failures reach the testbench summary
./obj_dir/tb_peri_top_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -qx "sim passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

//--- sim.f
source/axi4l_pkg.sv
source/axi4l_if.sv
source/axi4l_addr_decoder.sv
source/axi4l_register.sv
source/axi4l_bram.sv
source/peri_top.sv
testbench/peri_top_assert.sv
testbench/tb_peri_top.sv

//--- source/axi4l_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module axi4l_addr_decoder #(
    parameter int                          NUM  = 2,
    parameter axi4l_pkg::addr_t [NUM-1:0] BASE = '0,
    parameter axi4l_pkg::addr_t [NUM-1:0] HIGH = '0
) (
    input  logic     clk,
    input  logic     reset,
    axi4l_if.subordinate s_axi4l,
    axi4l_if.manager     m_axi4l [NUM]
);

    // index NUM stands for the local decode error responder
    localparam int SEL_BITS = $clog2(NUM + 1);

    logic [SEL_BITS-1:0] aw_sel;
    logic [SEL_BITS-1:0] ar_sel;
    logic [SEL_BITS-1:0] wr_owner;
    logic [SEL_BITS-1:0] rd_owner;
    logic                wr_busy;
    logic                rd_busy;
    logic                wr_take;
    logic                rd_take;
    logic                wr_done;
    logic                rd_done;

    // per window view of the return signals, the last entry is the error responder
    logic [NUM:0]     aw_ready;
    logic [NUM:0]     w_ready;
    logic [NUM:0]     ar_ready;
    logic [NUM:0]     b_valid;
    logic [NUM:0]     r_valid;
    axi4l_pkg::resp_t b_resp [NUM+1];
    axi4l_pkg::resp_t r_resp [NUM+1];
    axi4l_pkg::data_t r_data [NUM+1];

    // lowest matching window wins when windows overlap
    function automatic logic [SEL_BITS-1:0] decode(input axi4l_pkg::addr_t addr);
        logic [SEL_BITS-1:0] sel;
        sel = SEL_BITS'(NUM);
        for (int i = NUM - 1; i >= 0; i--) begin
            if (addr >= BASE[i] && addr <= HIGH[i]) begin
                sel = SEL_BITS'(i);
            end
        end
        return sel;
    endfunction

    assign aw_sel = decode(s_axi4l.awaddr);
    assign ar_sel = decode(s_axi4l.araddr);

    for (genvar i = 0; i < NUM; i++) begin : g_win
        // windows see addresses relative to their own base
        assign m_axi4l[i].awaddr  = s_axi4l.awaddr - BASE[i];
        assign m_axi4l[i].awprot  = s_axi4l.awprot;
        assign m_axi4l[i].awvalid = s_axi4l.awvalid & ~wr_busy & (aw_sel == SEL_BITS'(i));
        assign m_axi4l[i].wdata   = s_axi4l.wdata;
        assign m_axi4l[i].wstrb   = s_axi4l.wstrb;
        assign m_axi4l[i].wvalid  = s_axi4l.wvalid & ~wr_busy & (aw_sel == SEL_BITS'(i));
        assign m_axi4l[i].bready  = s_axi4l.bready & wr_busy & (wr_owner == SEL_BITS'(i));
        assign m_axi4l[i].araddr  = s_axi4l.araddr - BASE[i];
        assign m_axi4l[i].arprot  = s_axi4l.arprot;
        assign m_axi4l[i].arvalid = s_axi4l.arvalid & ~rd_busy & (ar_sel == SEL_BITS'(i));
        assign m_axi4l[i].rready  = s_axi4l.rready & rd_busy & (rd_owner == SEL_BITS'(i));

        assign aw_ready[i] = m_axi4l[i].awready;
        assign w_ready[i]  = m_axi4l[i].wready;
        assign ar_ready[i] = m_axi4l[i].arready;
        assign b_valid[i]  = m_axi4l[i].bvalid;
        assign b_resp[i]   = m_axi4l[i].bresp;
        assign r_valid[i]  = m_axi4l[i].rvalid;
        assign r_resp[i]   = m_axi4l[i].rresp;
        assign r_data[i]   = m_axi4l[i].rdata;
    end

    // the error responder accepts at once and its response is simply the busy flag
    assign aw_ready[NUM] = s_axi4l.awvalid & s_axi4l.wvalid;
    assign w_ready[NUM]  = s_axi4l.awvalid & s_axi4l.wvalid;
    assign ar_ready[NUM] = s_axi4l.arvalid;
    assign b_valid[NUM]  = 1'b1;
    assign b_resp[NUM]   = axi4l_pkg::RESP_DECERR;
    assign r_valid[NUM]  = 1'b1;
    assign r_resp[NUM]   = axi4l_pkg::RESP_DECERR;
    assign r_data[NUM]   = '0;

    assign s_axi4l.awready = ~wr_busy & aw_ready[aw_sel];
    assign s_axi4l.wready  = ~wr_busy & w_ready[aw_sel];
    assign s_axi4l.arready = ~rd_busy & ar_ready[ar_sel];
    assign s_axi4l.bvalid  = wr_busy & b_valid[wr_owner];
    assign s_axi4l.bresp   = b_resp[wr_owner];
    assign s_axi4l.rvalid  = rd_busy & r_valid[rd_owner];
    assign s_axi4l.rresp   = r_resp[rd_owner];
    assign s_axi4l.rdata   = r_data[rd_owner];

    // windows raise awready and wready together, so one handshake marks the write
    assign wr_take = s_axi4l.awvalid & s_axi4l.awready;
    assign rd_take = s_axi4l.arvalid & s_axi4l.arready;
    assign wr_done = wr_busy & b_valid[wr_owner] & s_axi4l.bready;
    assign rd_done = rd_busy & r_valid[rd_owner] & s_axi4l.rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_busy  <= 1'b0;
            wr_owner <= '0;
        end else if (wr_take) begin
            wr_busy  <= 1'b1;
            wr_owner <= aw_sel;  // remembered until the response transfers
        end else if (wr_done) begin
            wr_busy  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy  <= 1'b0;
            rd_owner <= '0;
        end else if (rd_take) begin
            rd_busy  <= 1'b1;
            rd_owner <= ar_sel;
        end else if (rd_done) begin
            rd_busy  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/axi4l_bram.sv
`timescale 1ns/1ps
`default_nettype none

module axi4l_bram #(
    parameter int WORDS = 256
) (
    input  logic         clk,
    input  logic         reset,
    axi4l_if.subordinate s_axi4l
);

    // WORDS is a power of two, so the index slice wraps the word address modulo WORDS
    localparam int IDX_BITS = $clog2(WORDS);

    axi4l_pkg::data_t    mem [WORDS];
    axi4l_pkg::data_t    rdata_q;
    logic [IDX_BITS-1:0] aw_idx;
    logic [IDX_BITS-1:0] ar_idx;
    logic                wr_take;
    logic                rd_take;
    logic                bvalid_q;
    logic                rvalid_q;

    assign aw_idx = s_axi4l.awaddr[IDX_BITS+1:2];
    assign ar_idx = s_axi4l.araddr[IDX_BITS+1:2];

    assign wr_take = s_axi4l.awvalid & s_axi4l.wvalid & ~bvalid_q;
    assign rd_take = s_axi4l.arvalid & ~rvalid_q;

    assign s_axi4l.awready = wr_take;
    assign s_axi4l.wready  = wr_take;
    assign s_axi4l.bvalid  = bvalid_q;
    assign s_axi4l.bresp   = axi4l_pkg::RESP_OKAY;
    assign s_axi4l.arready = rd_take;
    assign s_axi4l.rvalid  = rvalid_q;
    assign s_axi4l.rresp   = axi4l_pkg::RESP_OKAY;
    assign s_axi4l.rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (wr_take) begin
            for (int b = 0; b < axi4l_pkg::STRB_BITS; b++) begin
                if (s_axi4l.wstrb[b]) begin
                    mem[aw_idx][b*8 +: 8] <= s_axi4l.wdata[b*8 +: 8];
                end
            end
        end
        // synchronous read port, the output register is the block RAM's own
        if (rd_take) begin
            rdata_q <= mem[ar_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_take) begin
                bvalid_q <= 1'b1;
            end else if (s_axi4l.bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_take) begin
                rvalid_q <= 1'b1;
            end else if (s_axi4l.rready) begin
                rvalid_q <= 1'b0;  // response drops once the host takes it
            end
        end
    end

endmodule

`default_nettype wire

//--- source/axi4l_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi4l_if;

    // write address channel
    axi4l_pkg::addr_t awaddr;
    axi4l_pkg::prot_t awprot;
    logic             awvalid;
    logic             awready;

    // write data channel
    axi4l_pkg::data_t wdata;
    axi4l_pkg::strb_t wstrb;
    logic             wvalid;
    logic             wready;

    // write response channel
    axi4l_pkg::resp_t bresp;
    logic             bvalid;
    logic             bready;

    // read address channel
    axi4l_pkg::addr_t araddr;
    axi4l_pkg::prot_t arprot;
    logic             arvalid;
    logic             arready;

    // read data channel
    axi4l_pkg::data_t rdata;
    axi4l_pkg::resp_t rresp;
    logic             rvalid;
    logic             rready;

    modport manager (
        output awaddr, awprot, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arprot, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport subordinate (
        input awaddr, awprot, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arprot, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

`default_nettype wire

//--- source/axi4l_pkg.sv
`default_nettype none

package axi4l_pkg;

    // bus geometry shared by every block on the host bus
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = DATA_BITS / 8;  // one strobe per byte lane

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [STRB_BITS-1:0] strb_t;

    // response codes as defined by AXI4-Lite, only two of the four are produced here
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;  // normal completion
    localparam resp_t RESP_DECERR = 2'b11;  // no window claims the address

    // protection bits travel with the address but nothing here decodes them
    typedef logic [2:0] prot_t;

endpackage

`default_nettype wire

//--- source/axi4l_register.sv
`timescale 1ns/1ps
`default_nettype none

module axi4l_register #(
    parameter int NUM = 4
) (
    input  logic           clk,
    input  logic           reset,
    axi4l_if.subordinate   s_axi4l,
    output logic [NUM-1:0] value
);

    // word offset within the window, the decoder has already removed the base
    localparam int WORD_BITS = axi4l_pkg::ADDR_BITS - 2;

    logic [WORD_BITS-1:0] aw_word;
    logic [WORD_BITS-1:0] ar_word;
    logic                 wr_take;
    logic                 rd_take;
    logic                 bvalid_q;
    logic                 rvalid_q;
    logic                 rd_bit;
    axi4l_pkg::data_t     rdata_q;

    assign aw_word = s_axi4l.awaddr[axi4l_pkg::ADDR_BITS-1:2];
    assign ar_word = s_axi4l.araddr[axi4l_pkg::ADDR_BITS-1:2];

    assign wr_take = s_axi4l.awvalid & s_axi4l.wvalid & ~bvalid_q;
    assign rd_take = s_axi4l.arvalid & ~rvalid_q;

    assign s_axi4l.awready = wr_take;
    assign s_axi4l.wready  = wr_take;
    assign s_axi4l.bvalid  = bvalid_q;
    assign s_axi4l.bresp   = axi4l_pkg::RESP_OKAY;
    assign s_axi4l.arready = rd_take;
    assign s_axi4l.rvalid  = rvalid_q;
    assign s_axi4l.rresp   = axi4l_pkg::RESP_OKAY;
    assign s_axi4l.rdata   = rdata_q;

    always_comb begin
        rd_bit = 1'b0;  // offsets past the last register read as zero
        for (int n = 0; n < NUM; n++) begin
            if (ar_word == WORD_BITS'(n)) begin
                rd_bit = value[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            value    <= '0;
            bvalid_q <= 1'b0;
        end else begin
            if (wr_take) begin
                bvalid_q <= 1'b1;
                for (int n = 0; n < NUM; n++) begin
                    if (aw_word == WORD_BITS'(n) && s_axi4l.wstrb[0]) begin
                        value[n] <= s_axi4l.wdata[0];  // only lane 0 bit 0 matters
                    end
                end
            end else if (s_axi4l.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else if (rd_take) begin
            rvalid_q <= 1'b1;
        end else if (s_axi4l.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // read data is captured with the request and held until rready
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata_q <= axi4l_pkg::data_t'(rd_bit);
        end
    end

endmodule

`default_nettype wire

//--- source/peri_top.sv
`timescale 1ns/1ps
`default_nettype none

module peri_top #(
    parameter axi4l_pkg::addr_t REG_BASE       = 32'h4000_0000,
    parameter axi4l_pkg::addr_t REG_HIGH       = 32'h4000_0fff,
    parameter axi4l_pkg::addr_t MEM_BASE       = 32'h4001_0000,
    parameter axi4l_pkg::addr_t MEM_HIGH       = 32'h4001_ffff,
    parameter int               REG_NUM        = 4,
    parameter int               MEM_WORDS      = 256,
    parameter int               HEARTBEAT_BITS = 28
) (
    input  logic             clk,
    input  logic             reset,

    input  axi4l_pkg::addr_t host_awaddr,
    input  axi4l_pkg::prot_t host_awprot,
    input  logic             host_awvalid,
    output logic             host_awready,
    input  axi4l_pkg::data_t host_wdata,
    input  axi4l_pkg::strb_t host_wstrb,
    input  logic             host_wvalid,
    output logic             host_wready,
    output axi4l_pkg::resp_t host_bresp,
    output logic             host_bvalid,
    input  logic             host_bready,
    input  axi4l_pkg::addr_t host_araddr,
    input  axi4l_pkg::prot_t host_arprot,
    input  logic             host_arvalid,
    output logic             host_arready,
    output axi4l_pkg::data_t host_rdata,
    output axi4l_pkg::resp_t host_rresp,
    output logic             host_rvalid,
    input  logic             host_rready,

    output logic [7:0]       pmod
);

    logic [REG_NUM-1:0]        reg_value;
    logic [HEARTBEAT_BITS-1:0] heartbeat;

    axi4l_if host_bus ();
    axi4l_if win_bus [2] ();  // 0 is the register bank, 1 the memory

    assign host_bus.awaddr  = host_awaddr;
    assign host_bus.awprot  = host_awprot;
    assign host_bus.awvalid = host_awvalid;
    assign host_awready     = host_bus.awready;
    assign host_bus.wdata   = host_wdata;
    assign host_bus.wstrb   = host_wstrb;
    assign host_bus.wvalid  = host_wvalid;
    assign host_wready      = host_bus.wready;
    assign host_bresp       = host_bus.bresp;
    assign host_bvalid      = host_bus.bvalid;
    assign host_bus.bready  = host_bready;
    assign host_bus.araddr  = host_araddr;
    assign host_bus.arprot  = host_arprot;
    assign host_bus.arvalid = host_arvalid;
    assign host_arready     = host_bus.arready;
    assign host_rdata       = host_bus.rdata;
    assign host_rresp       = host_bus.rresp;
    assign host_rvalid      = host_bus.rvalid;
    assign host_bus.rready  = host_rready;

    axi4l_addr_decoder #(
        .NUM  (2),
        .BASE ({MEM_BASE, REG_BASE}),
        .HIGH ({MEM_HIGH, REG_HIGH})
    ) u_addr_decoder (
        .clk     (clk),
        .reset   (reset),
        .s_axi4l (host_bus),
        .m_axi4l (win_bus)
    );

    axi4l_register #(
        .NUM (REG_NUM)
    ) u_register (
        .clk     (clk),
        .reset   (reset),
        .s_axi4l (win_bus[0]),
        .value   (reg_value)
    );

    axi4l_bram #(
        .WORDS (MEM_WORDS)
    ) u_bram (
        .clk     (clk),
        .reset   (reset),
        .s_axi4l (win_bus[1])
    );

    // free running, its top nibble blinks the upper half of the pmod
    always_ff @(posedge clk) begin
        if (reset) begin
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
        end
    end

    assign pmod[3:0] = 4'(reg_value);
    assign pmod[7:4] = heartbeat[HEARTBEAT_BITS-1 -: 4];

endmodule

`default_nettype wire

//--- testbench/peri_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module peri_top_assert (
    input logic             clk,
    input logic             reset,
    input logic             host_awready,
    input logic             host_bvalid,
    input logic             host_bready,
    input axi4l_pkg::resp_t host_bresp,
    input logic             host_rvalid,
    input logic             host_rready,
    input axi4l_pkg::resp_t host_rresp,
    input axi4l_pkg::data_t host_rdata
);

    int fail_count = 0;  // read by the testbench at the end of the run

    idle_after_reset: assert property (@(posedge clk) reset |=> !host_bvalid && !host_rvalid)
        else begin
            $error("response valid after reset");
            fail_count++;
        end

    // a waiting response keeps its payload until the host takes it
    b_held: assert property (@(posedge clk) disable iff (reset)
        host_bvalid && !host_bready |=> host_bvalid && $stable(host_bresp))
        else begin
            $error("write response changed while waiting");
            fail_count++;
        end

    r_held: assert property (@(posedge clk) disable iff (reset)
        host_rvalid && !host_rready |=> host_rvalid && $stable(host_rdata) && $stable(host_rresp))
        else begin
            $error("read response changed while waiting");
            fail_count++;
        end

    no_aw_while_pending: assert property (@(posedge clk) disable iff (reset)
        host_bvalid |-> !host_awready)
        else begin
            $error("write accepted with a response pending");
            fail_count++;
        end

endmodule

bind peri_top peri_top_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .host_awready (host_awready),
    .host_bvalid  (host_bvalid),
    .host_bready  (host_bready),
    .host_bresp   (host_bresp),
    .host_rvalid  (host_rvalid),
    .host_rready  (host_rready),
    .host_rresp   (host_rresp),
    .host_rdata   (host_rdata)
);

`default_nettype wire

//--- testbench/tb_peri_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_peri_top;

    localparam axi4l_pkg::addr_t REG_BASE  = 32'h4000_0000;
    localparam axi4l_pkg::addr_t REG_HIGH  = 32'h4000_0fff;
    localparam axi4l_pkg::addr_t MEM_BASE  = 32'h4001_0000;
    localparam axi4l_pkg::addr_t MEM_HIGH  = 32'h4001_ffff;
    localparam int               REG_NUM   = 4;
    localparam int               MEM_WORDS = 256;
    localparam int               TIMEOUT   = 50;  // cycles allowed for any single wait
    localparam bit               OP_WR     = 1'b0;
    localparam bit               OP_RD     = 1'b1;

    logic             clk;
    logic             reset;
    axi4l_pkg::addr_t host_awaddr;
    axi4l_pkg::addr_t host_araddr;
    axi4l_pkg::prot_t host_awprot;
    axi4l_pkg::prot_t host_arprot;
    axi4l_pkg::data_t host_wdata;
    axi4l_pkg::data_t host_rdata;
    axi4l_pkg::strb_t host_wstrb;
    axi4l_pkg::resp_t host_bresp;
    axi4l_pkg::resp_t host_rresp;
    logic             host_awvalid, host_awready, host_wvalid, host_wready;
    logic             host_bvalid, host_bready;
    logic             host_arvalid, host_arready, host_rvalid, host_rready;
    logic [7:0]       pmod;

    // stimulus table, one entry per bus transaction
    string            step_name [$];
    bit               step_op   [$];
    axi4l_pkg::addr_t step_addr [$];
    axi4l_pkg::data_t step_data [$];
    axi4l_pkg::strb_t step_strb [$];
    axi4l_pkg::resp_t step_resp [$];
    axi4l_pkg::data_t step_exp  [$];  // read data, or pmod[3:0] after a write

    logic [REG_NUM-1:0] reg_model;
    axi4l_pkg::data_t   mem_model [MEM_WORDS];  // byte-accurate image of the memory window
    logic [31:0]        rng_state = 32'h331ad494;
    int                 checks = 0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    bit                 hb_done = 1'b0;

    peri_top #(
        .REG_BASE       (REG_BASE),
        .REG_HIGH       (REG_HIGH),
        .MEM_BASE       (MEM_BASE),
        .MEM_HIGH       (MEM_HIGH),
        .REG_NUM        (REG_NUM),
        .MEM_WORDS      (MEM_WORDS),
        .HEARTBEAT_BITS (8)
    ) uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input axi4l_pkg::data_t exp,
                               input axi4l_pkg::data_t act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        other_errors++;
    endtask

    task automatic store_step(input string name, input bit op, input axi4l_pkg::addr_t addr,
                              input axi4l_pkg::data_t data, input axi4l_pkg::strb_t strb,
                              input axi4l_pkg::resp_t resp, input axi4l_pkg::data_t exp);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_strb.push_back(strb);
        step_resp.push_back(resp);
        step_exp.push_back(exp);
    endtask

    // applies the write to the models, so later reads know what to expect
    task automatic push_write(input string name, input axi4l_pkg::addr_t addr,
                              input axi4l_pkg::data_t data, input axi4l_pkg::strb_t strb);
        int unsigned      idx;
        axi4l_pkg::resp_t resp;
        resp = axi4l_pkg::RESP_OKAY;
        if (addr >= REG_BASE && addr <= REG_HIGH) begin
            idx = (addr - REG_BASE) >> 2;
            if (idx < REG_NUM && strb[0]) begin
                reg_model[idx] = data[0];
            end
        end else if (addr >= MEM_BASE && addr <= MEM_HIGH) begin
            idx = ((addr - MEM_BASE) >> 2) % MEM_WORDS;  // word index wraps
            for (int b = 0; b < axi4l_pkg::STRB_BITS; b++) begin
                if (strb[b]) begin
                    mem_model[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else begin
            resp = axi4l_pkg::RESP_DECERR;
        end
        store_step(name, OP_WR, addr, data, strb, resp, axi4l_pkg::data_t'(reg_model));
    endtask

    task automatic push_read(input string name, input axi4l_pkg::addr_t addr);
        int unsigned      idx;
        axi4l_pkg::resp_t resp;
        axi4l_pkg::data_t exp;
        resp = axi4l_pkg::RESP_OKAY;
        exp = '0;
        if (addr >= REG_BASE && addr <= REG_HIGH) begin
            idx = (addr - REG_BASE) >> 2;
            if (idx < REG_NUM) begin
                exp = axi4l_pkg::data_t'(reg_model[idx]);
            end
        end else if (addr >= MEM_BASE && addr <= MEM_HIGH) begin
            idx = ((addr - MEM_BASE) >> 2) % MEM_WORDS;
            exp = mem_model[idx];
        end else begin
            resp = axi4l_pkg::RESP_DECERR;  // decode errors carry zero data
        end
        store_step(name, OP_RD, addr, '0, '0, resp, exp);
    endtask

    task automatic build_table();
        reg_model = '0;
        push_write("reg0 set", REG_BASE, 32'h1, 4'b0001);
        push_write("reg2 set", REG_BASE + 32'h8, 32'h1, 4'b1111);
        push_write("reg3 set", REG_BASE + 32'hc, 32'hffff_ffff, 4'b0001);
        push_write("reg1 set", REG_BASE + 32'h4, 32'h1, 4'b0001);
        push_write("reg0 clear", REG_BASE, 32'h0, 4'b0001);
        push_write("reg1 no strobe", REG_BASE + 32'h4, 32'h0, 4'b1110);
        push_write("reg4 ignored", REG_BASE + 32'h10, 32'h1, 4'b0001);
        for (int i = 0; i < 6; i++) begin
            push_read($sformatf("reg read %0d", i), REG_BASE + 32'(4 * i));
        end
        for (int i = 0; i < 8; i++) begin
            push_write($sformatf("mem fill %0d", i), MEM_BASE + 32'(4 * i), next_random(),
                       4'b1111);
        end
        push_write("mem partial 1", MEM_BASE + 32'h4, next_random(), 4'b0101);
        push_write("mem partial 3", MEM_BASE + 32'hc, next_random(), 4'b1000);
        push_write("mem wrap write", MEM_BASE + 32'(4 * (MEM_WORDS + 2)), next_random(),
                   4'b0110);
        push_read("mem wrap read", MEM_BASE + 32'(4 * (MEM_WORDS + 5)));
        push_write("unmapped low", 32'h0000_1000, 32'hffff_ffff, 4'b1111);
        push_write("unmapped reg gap", REG_HIGH + 32'h1, 32'hffff_ffff, 4'b1111);
        push_write("unmapped mem end", MEM_HIGH + 32'h5, next_random(), 4'b1111);
        push_read("unmapped read low", 32'h0000_1000);
        push_read("unmapped read high", MEM_HIGH + 32'h5);
        for (int i = 0; i < 8; i++) begin
            push_read($sformatf("mem read %0d", i), MEM_BASE + 32'(4 * i));
        end
        push_read("reg3 recheck", REG_BASE + 32'hc);
    endtask

    task automatic write_word(input string name, input axi4l_pkg::addr_t addr,
                              input axi4l_pkg::data_t data, input axi4l_pkg::strb_t strb,
                              output axi4l_pkg::resp_t resp, output int latency);
        int waited;
        int stall;
        stall = int'(next_random() % 4);
        @(negedge clk);
        host_awaddr = addr;
        host_wdata = data;
        host_wstrb = strb;
        host_awvalid = 1'b1;
        host_wvalid = 1'b1;
        waited = 0;
        #1;
        while (!(host_awready && host_wready) && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        assert (waited < TIMEOUT) else report_timeout({name, " write acceptance"});
        @(negedge clk);  // the transfer happened on the rising edge before this one
        host_awvalid = 1'b0;
        host_wvalid = 1'b0;
        latency = 1;
        while (!host_bvalid && latency <= TIMEOUT) begin
            @(negedge clk);
            latency++;
        end
        assert (latency <= TIMEOUT) else report_timeout({name, " bvalid"});
        repeat (stall) @(negedge clk);
        host_bready = 1'b1;
        resp = host_bresp;
        @(negedge clk);
        host_bready = 1'b0;
    endtask

    task automatic fetch_word(input string name, input axi4l_pkg::addr_t addr,
                              output axi4l_pkg::resp_t resp, output axi4l_pkg::data_t data,
                              output int latency);
        int waited;
        int stall;
        stall = int'(next_random() % 4);
        @(negedge clk);
        host_araddr = addr;
        host_arvalid = 1'b1;
        waited = 0;
        #1;
        while (!host_arready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        assert (waited < TIMEOUT) else report_timeout({name, " read acceptance"});
        @(negedge clk);
        host_arvalid = 1'b0;
        latency = 1;
        while (!host_rvalid && latency <= TIMEOUT) begin
            @(negedge clk);
            latency++;
        end
        assert (latency <= TIMEOUT) else report_timeout({name, " rvalid"});
        repeat (stall) @(negedge clk);  // rready held low, data must stay put
        host_rready = 1'b1;
        resp = host_rresp;
        data = host_rdata;
        @(negedge clk);
        host_rready = 1'b0;
    endtask

    initial begin : heartbeat_monitor
        logic [3:0] prev;
        int         gap;
        int         waited;
        waited = 0;
        @(negedge clk);
        #1;
        while (reset && waited < 100) begin
            @(negedge clk);
            #1;
            waited++;
        end
        assert (waited < 100) else report_timeout("reset release");
        check_value("heartbeat start", '0, axi4l_pkg::data_t'(pmod[7:4]));
        prev = pmod[7:4];
        gap = 0;
        while (!hb_done) begin
            @(negedge clk);
            #1;
            gap++;
            if (pmod[7:4] != prev) begin
                check_value("heartbeat step", axi4l_pkg::data_t'(4'(prev + 4'd1)),
                            axi4l_pkg::data_t'(pmod[7:4]));
                prev = pmod[7:4];
                gap = 0;
            end
            assert (gap <= 64) else begin
                $display("heartbeat nibble did not change within 64 cycles");
                other_errors++;
                gap = 0;
            end
        end
    end

    initial begin
        axi4l_pkg::resp_t resp;
        axi4l_pkg::data_t data;
        int               latency;
        int               rule_errors;
        reset = 1'b1;
        host_awaddr = '0;
        host_awprot = '0;
        host_awvalid = 1'b0;
        host_wdata = '0;
        host_wstrb = '0;
        host_wvalid = 1'b0;
        host_bready = 1'b0;
        host_araddr = '0;
        host_arprot = '0;
        host_arvalid = 1'b0;
        host_rready = 1'b0;
        build_table();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < step_name.size(); i++) begin
            if (step_op[i] == OP_WR) begin
                write_word(step_name[i], step_addr[i], step_data[i], step_strb[i], resp, latency);
                check_value({step_name[i], " bresp"}, axi4l_pkg::data_t'(step_resp[i]),
                            axi4l_pkg::data_t'(resp));
                check_value({step_name[i], " pmod"}, step_exp[i], axi4l_pkg::data_t'(pmod[3:0]));
            end else begin
                fetch_word(step_name[i], step_addr[i], resp, data, latency);
                check_value({step_name[i], " rresp"}, axi4l_pkg::data_t'(step_resp[i]),
                            axi4l_pkg::data_t'(resp));
                check_value({step_name[i], " rdata"}, step_exp[i], data);
            end
            check_value({step_name[i], " latency"}, 32'd1, axi4l_pkg::data_t'(latency));
        end
        hb_done = 1'b1;
        @(negedge clk);
        rule_errors = uut.u_assert.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, bus rule errors %0d",
                 checks, value_errors, other_errors, rule_errors);
        if (value_errors == 0 && other_errors == 0 && rule_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
